// ==== compile.f ====
src/mix_pkg.sv
src/slot_if.sv
src/slot_counter.sv
src/op_stage_fsm.sv
src/mix_select.sv
src/frame_acc.sv
src/fm_mixer_top.sv
test/tb_fm_mixer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fm_mixer
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_fm_mixer.sv ====
module tb_fm_mixer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES    = 14;
    localparam int RESET_CYCLES   = 10;
    localparam int SLOTS          = mix_pkg::SLOTS_PER_FRAME;
    // Eight clocks per slot is far above the average clk_en rate
    localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + 2) * SLOTS * 8 + RESET_CYCLES;

    logic                clk;
    logic                rst_n;
    logic                clk_en;
    mix_pkg::op_result_t op_result;
    mix_pkg::rl_t        rl;
    mix_pkg::alg_t       alg;
    mix_pkg::sample_t    adpcma_l;
    mix_pkg::sample_t    adpcma_r;
    mix_pkg::sample_t    adpcmb_l;
    mix_pkg::sample_t    adpcmb_r;
    mix_pkg::ch_t        cur_ch;
    mix_pkg::op_t        cur_op;
    logic                frame_start;
    mix_pkg::sample_t    left;
    mix_pkg::sample_t    right;

    logic [31:0] rand_state;
    int          errors = 0;
    int          cycles = 0;
    int          n_loaded = 0;

    // Stimulus table, one entry per frame
    string               name_tab [NUM_ENTRIES];
    mix_pkg::alg_t       alg_tab  [NUM_ENTRIES];
    mix_pkg::rl_t        rl_tab   [NUM_ENTRIES];
    mix_pkg::op_result_t op_tab   [NUM_ENTRIES];
    mix_pkg::sample_t    al_tab   [NUM_ENTRIES];
    mix_pkg::sample_t    ar_tab   [NUM_ENTRIES];
    mix_pkg::sample_t    bl_tab   [NUM_ENTRIES];
    mix_pkg::sample_t    br_tab   [NUM_ENTRIES];
    mix_pkg::sample_t    exp_l    [NUM_ENTRIES];
    mix_pkg::sample_t    exp_r    [NUM_ENTRIES];

    fm_mixer_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .op_result   (op_result),
        .rl          (rl),
        .alg         (alg),
        .adpcma_l    (adpcma_l),
        .adpcma_r    (adpcma_r),
        .adpcmb_l    (adpcmb_l),
        .adpcmb_r    (adpcmb_r),
        .cur_ch      (cur_ch),
        .cur_op      (cur_op),
        .frame_start (frame_start),
        .left        (left),
        .right       (right)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Enabled on roughly three clocks in four
    always @(posedge clk) begin
        rand_state <= xorshift32(rand_state);
        clk_en     <= (rand_state[1:0] != 2'b00);
    end

    // Channel index at a position within one stage
    function automatic int channel_at(input int pos);
        case (pos)
            0:       return 0;
            1:       return 1;
            2:       return 2;
            3:       return 4;
            4:       return 5;
            default: return 6;
        endcase
    endfunction

    // Stage index runs S1, S3, S2, S4
    function automatic logic is_carrier(input int a, input int stage);
        int opn;
        case (stage)
            0:       opn = 1;
            1:       opn = 3;
            2:       opn = 2;
            default: opn = 4;
        endcase
        if (a <= 3) begin
            return (opn == 4);
        end else if (a == 4) begin
            return (opn == 2) || (opn == 4);
        end else if (a == 7) begin
            return 1'b1;
        end
        return (opn != 1);
    endfunction

    // Reference frame sum for one side
    function automatic mix_pkg::sample_t side_total(input int a, input logic en, input int op,
                                                    input int pa, input int pb);
        int count;
        int total;
        count = 0;
        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 6; c++) begin
                // S1 slots of channels 0 and 4 carry ADPCM
                if (is_carrier(a, s) && !(s == 0 && (channel_at(c) == 0 || channel_at(c) == 4)))
                    count++;
            end
        end
        total = en ? count * (op >>> 1) : 0;
        total = total + pa * 6 + (pb >>> 1);
        if (total > 32767)
            total = 32767;
        if (total < -32768)
            total = -32768;
        return mix_pkg::sample_t'(total);
    endfunction

    task automatic add_entry(input string name, input int a, input int r, input int op,
                             input int al, input int ar, input int bl, input int br);
        name_tab[n_loaded] = name;
        alg_tab[n_loaded]  = mix_pkg::alg_t'(a);
        rl_tab[n_loaded]   = mix_pkg::rl_t'(r);
        op_tab[n_loaded]   = mix_pkg::op_result_t'(op);
        al_tab[n_loaded]   = mix_pkg::sample_t'(al);
        ar_tab[n_loaded]   = mix_pkg::sample_t'(ar);
        bl_tab[n_loaded]   = mix_pkg::sample_t'(bl);
        br_tab[n_loaded]   = mix_pkg::sample_t'(br);
        exp_l[n_loaded]    = side_total(a, r[1], op, al, bl);
        exp_r[n_loaded]    = side_total(a, r[0], op, ar, br);
        n_loaded++;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    // Returns at a negedge where the shown slot will be consumed
    task automatic wait_slot();
        do begin
            @(negedge clk);
        end while (!clk_en);
    endtask

    task automatic check_slot(input int idx);
        check_value($sformatf("slot %0d cur_ch", idx), channel_at(idx % 6), int'(cur_ch));
        check_value($sformatf("slot %0d cur_op", idx), idx / 6, int'(cur_op));
        check_value($sformatf("slot %0d frame_start", idx), (idx == 0) ? 1 : 0,
                    int'(frame_start));
    endtask

    task automatic check_entry(input int e);
        check_value({name_tab[e], " left"}, int'(exp_l[e]), int'(left));
        check_value({name_tab[e], " right"}, int'(exp_r[e]), int'(right));
    endtask

    // Called right on a rising edge
    task automatic apply_entry(input int e);
        alg       <= alg_tab[e];
        rl        <= rl_tab[e];
        op_result <= op_tab[e];
        adpcma_l  <= al_tab[e];
        adpcma_r  <= ar_tab[e];
        adpcmb_l  <= bl_tab[e];
        adpcmb_r  <= br_tab[e];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the frames did not complete within %0d clock cycles", cycles);
            $display("Errors: %0d", errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        clk_en     = 1'b0;
        rand_state = 32'h227f_c1ad;
        op_result  = '0;
        rl         = '0;
        alg        = '0;
        adpcma_l   = '0;
        adpcma_r   = '0;
        adpcmb_l   = '0;
        adpcmb_r   = '0;

        // Carrier rule, every algorithm
        add_entry("alg0", 0, 3, 1000, 0, 0, 0, 0);
        add_entry("alg1", 1, 3, -1000, 0, 0, 0, 0);
        add_entry("alg2", 2, 3, 333, 0, 0, 0, 0);
        add_entry("alg3", 3, 3, -333, 0, 0, 0, 0);
        add_entry("alg4", 4, 3, 1200, 0, 0, 0, 0);
        add_entry("alg5", 5, 3, 801, 0, 0, 0, 0);
        add_entry("alg6", 6, 3, -801, 0, 0, 0, 0);
        add_entry("alg7", 7, 3, 1000, 0, 0, 0, 0);
        // Side enables, ADPCM still on both sides
        add_entry("rl_left_only", 7, 2, 1000, 100, -100, 50, -51);
        add_entry("rl_right_only", 4, 1, 2000, 10, 20, 40, -40);
        add_entry("rl_none", 7, 0, 3000, -7, 9, -3, 5);
        add_entry("adpcm_only", 0, 3, 0, -1234, 2345, -777, 1001);
        // Clamp at both limits
        add_entry("sat_pos", 7, 3, 8191, 5000, 5000, 30000, 30000);
        add_entry("sat_neg", 7, 3, -8192, -5000, -5000, -30000, -30000);

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("after_reset left", 0, int'(left));
        check_value("after_reset right", 0, int'(right));
        check_value("after_reset cur_ch", 0, int'(cur_ch));
        check_value("after_reset cur_op", 0, int'(cur_op));
        check_value("after_reset frame_start", 1, int'(frame_start));
        @(posedge clk);
        rst_n <= 1'b1;

        // Frame 0 runs with zero inputs, entry f applies in frame f + 1
        for (int f = 0; f <= NUM_ENTRIES; f++) begin
            for (int idx = 0; idx < SLOTS; idx++) begin
                wait_slot();
                check_slot(idx);
                // Previous frame total is held from slot 1 on
                if (idx == 1 && f >= 2)
                    check_entry(f - 2);
                if (idx == SLOTS - 1 && f < NUM_ENTRIES) begin
                    @(posedge clk);
                    apply_entry(f);
                end
            end
        end
        // Last entry shows up at the start of the closing frame
        wait_slot();
        check_slot(0);
        wait_slot();
        check_slot(1);
        check_entry(NUM_ENTRIES - 1);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src/fm_mixer_top.sv ====
module fm_mixer_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  mix_pkg::op_result_t op_result,
    input  mix_pkg::rl_t        rl,
    input  mix_pkg::alg_t       alg,
    input  mix_pkg::sample_t    adpcma_l,
    input  mix_pkg::sample_t    adpcma_r,
    input  mix_pkg::sample_t    adpcmb_l,
    input  mix_pkg::sample_t    adpcmb_r,
    output mix_pkg::ch_t        cur_ch,
    output mix_pkg::op_t        cur_op,
    output logic                frame_start,
    output mix_pkg::sample_t    left,
    output mix_pkg::sample_t    right
);

    mix_pkg::ch_t     ch;
    logic             stage_end;
    mix_pkg::sample_t add_value_l;
    mix_pkg::sample_t add_value_r;
    logic             add_en_l;
    logic             add_en_r;

    // Slot position bundle
    slot_if slot ();

    // Channel timer
    slot_counter u_slot_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .ch        (ch),
        .stage_end (stage_end)
    );

    // Stage sequencing and frame start
    op_stage_fsm u_op_stage_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .ch        (ch),
        .stage_end (stage_end),
        .slot      (slot.producer)
    );

    // Per-slot contribution for each side
    mix_select u_mix_select (
        .slot        (slot.consumer),
        .op_result   (op_result),
        .rl          (rl),
        .alg         (alg),
        .adpcma_l    (adpcma_l),
        .adpcma_r    (adpcma_r),
        .adpcmb_l    (adpcmb_l),
        .adpcmb_r    (adpcmb_r),
        .add_value_l (add_value_l),
        .add_value_r (add_value_r),
        .add_en_l    (add_en_l),
        .add_en_r    (add_en_r)
    );

    // Left side frame sum
    frame_acc u_left (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .zero      (slot.zero),
        .add_value (add_value_l),
        .add_en    (add_en_l),
        .snd       (left)
    );

    // Right side frame sum
    frame_acc u_right (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .zero      (slot.zero),
        .add_value (add_value_r),
        .add_en    (add_en_r),
        .snd       (right)
    );

    // Slot position for the external operator source
    assign cur_ch      = slot.cur_ch;
    assign cur_op      = slot.cur_op;
    assign frame_start = slot.zero;

endmodule

// ==== src/frame_acc.sv ====
module frame_acc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clk_en,
    input  logic             zero,
    input  mix_pkg::sample_t add_value,
    input  logic             add_en,
    output mix_pkg::sample_t snd
);

    mix_pkg::acc_t    acc;
    mix_pkg::acc_t    add_ext;
    mix_pkg::sample_t sat_val;

    // Gated contribution, sign extended to accumulator width
    assign add_ext = add_en ? mix_pkg::acc_t'(add_value) : '0;

    // Clamp the frame sum to the sample range
    always_comb begin
        if (acc != mix_pkg::acc_t'(mix_pkg::sample_t'(acc))) begin
            // Out of range, pick the limit from the sign
            if (acc[$bits(mix_pkg::acc_t)-1]) begin
                sat_val = {1'b1, {($bits(mix_pkg::sample_t)-1){1'b0}}};
            end else begin
                sat_val = {1'b0, {($bits(mix_pkg::sample_t)-1){1'b1}}};
            end
        end else begin
            sat_val = mix_pkg::sample_t'(acc);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Publish last frame, restart with this slot
                snd <= sat_val;
                acc <= add_ext;
            end else begin
                acc <= acc + add_ext;
            end
        end
    end

endmodule

// ==== src/mix_select.sv ====
module mix_select (
    slot_if.consumer             slot,
    input  mix_pkg::op_result_t  op_result,
    input  mix_pkg::rl_t         rl,
    input  mix_pkg::alg_t        alg,
    input  mix_pkg::sample_t     adpcma_l,
    input  mix_pkg::sample_t     adpcma_r,
    input  mix_pkg::sample_t     adpcmb_l,
    input  mix_pkg::sample_t     adpcmb_r,
    output mix_pkg::sample_t     add_value_l,
    output mix_pkg::sample_t     add_value_r,
    output logic                 add_en_l,
    output logic                 add_en_r
);

    logic             carrier;
    logic             adpcma_slot;
    logic             adpcmb_slot;
    mix_pkg::sample_t op_ext;
    mix_pkg::sample_t op_half;

    // Carrier operators per algorithm
    always_comb begin
        case (alg)
            3'd4:       carrier = slot.s2_enters | slot.s4_enters;
            // Every stage but S1
            3'd5, 3'd6: carrier = ~slot.s1_enters;
            3'd7:       carrier = 1'b1;
            // Algorithms 0 to 3 sum the last operator only
            default:    carrier = slot.s4_enters;
        endcase
    end

    // Slots whose FM data is replaced by ADPCM
    assign adpcma_slot = (slot.cur_op == mix_pkg::op_t'(mix_pkg::ADPCM_STAGE))
                      && (slot.cur_ch == mix_pkg::ADPCMA_CH);
    assign adpcmb_slot = (slot.cur_op == mix_pkg::op_t'(mix_pkg::ADPCM_STAGE))
                      && (slot.cur_ch == mix_pkg::ADPCMB_CH);

    // Sign extend and halve
    assign op_ext  = mix_pkg::sample_t'(op_result);
    assign op_half = op_ext >>> 1;

    always_comb begin
        if (adpcma_slot) begin
            // Times 6 as 4x plus 2x
            add_value_l = (adpcma_l <<< 2) + (adpcma_l <<< 1);
            add_value_r = (adpcma_r <<< 2) + (adpcma_r <<< 1);
            add_en_l    = 1'b1;
            add_en_r    = 1'b1;
        end else if (adpcmb_slot) begin
            add_value_l = adpcmb_l >>> 1;
            add_value_r = adpcmb_r >>> 1;
            add_en_l    = 1'b1;
            add_en_r    = 1'b1;
        end else begin
            // Plain FM slot
            add_value_l = op_half;
            add_value_r = op_half;
            add_en_l    = carrier & rl[1];
            add_en_r    = carrier & rl[0];
        end
    end

endmodule

// ==== src/op_stage_fsm.sv ====
module op_stage_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clk_en,
    input  mix_pkg::ch_t    ch,
    input  logic            stage_end,
    slot_if.producer        slot
);

    mix_pkg::op_stage_e state;
    mix_pkg::op_stage_e state_next;

    // Chip order S1, S3, S2, S4
    always_comb begin
        state_next = state;
        if (stage_end) begin
            case (state)
                mix_pkg::STAGE_S1: state_next = mix_pkg::STAGE_S3;
                mix_pkg::STAGE_S3: state_next = mix_pkg::STAGE_S2;
                mix_pkg::STAGE_S2: state_next = mix_pkg::STAGE_S4;
                mix_pkg::STAGE_S4: state_next = mix_pkg::STAGE_S1;
                default:           state_next = mix_pkg::STAGE_S1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mix_pkg::STAGE_S1;
        end else if (clk_en) begin
            state <= state_next;
        end
    end

    // Slot position seen by the rest of the design
    assign slot.cur_ch = ch;
    // Encoding doubles as the stage index
    assign slot.cur_op = mix_pkg::op_t'(state);

    // Operator entry strobes
    assign slot.s1_enters = (state == mix_pkg::STAGE_S1);
    assign slot.s2_enters = (state == mix_pkg::STAGE_S2);
    assign slot.s3_enters = (state == mix_pkg::STAGE_S3);
    assign slot.s4_enters = (state == mix_pkg::STAGE_S4);

    // Stage S1 on channel 0 opens the frame
    assign slot.zero = (state == mix_pkg::STAGE_S1) && (ch == '0);

endmodule

// ==== src/slot_counter.sv ====
module slot_counter (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clk_en,
    output mix_pkg::ch_t ch,
    output logic         stage_end
);

    mix_pkg::ch_t ch_next;

    // Next channel, hopping over the unused index
    always_comb begin
        if (ch == mix_pkg::CH_LAST) begin
            ch_next = '0;
        end else if (ch + 3'd1 == mix_pkg::CH_SKIP) begin
            ch_next = ch + 3'd2;
        end else begin
            ch_next = ch + 3'd1;
        end
    end

    // One step per enabled clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch <= '0;
        end else if (clk_en) begin
            ch <= ch_next;
        end
    end

    // Last channel of the stage
    assign stage_end = (ch == mix_pkg::CH_LAST);

endmodule

// ==== src/slot_if.sv ====
interface slot_if;

    // Current slot position
    mix_pkg::ch_t cur_ch;
    mix_pkg::op_t cur_op;

    // One-hot, follows the stage in progress
    logic s1_enters;
    logic s2_enters;
    logic s3_enters;
    logic s4_enters;

    // First slot of the frame
    logic zero;

    modport producer (
        output cur_ch, cur_op,
        output s1_enters, s2_enters, s3_enters, s4_enters,
        output zero
    );

    modport consumer (
        input cur_ch, cur_op,
        input s1_enters, s2_enters, s3_enters, s4_enters,
        input zero
    );

endinterface

// ==== src/mix_pkg.sv ====
package mix_pkg;

    // Sample widths
    typedef logic signed [13:0] op_result_t;
    typedef logic signed [15:0] sample_t;
    // Room for 24 slot contributions before clamping
    typedef logic signed [18:0] acc_t;

    // Slot position
    typedef logic [2:0] ch_t;
    typedef logic [1:0] op_t;
    typedef logic [2:0] alg_t;
    // Bit 1 is left, bit 0 is right
    typedef logic [1:0] rl_t;

    // Operator stages in execution order, not operator number
    typedef enum logic [1:0] {
        STAGE_S1 = 2'd0,
        STAGE_S3 = 2'd1,
        STAGE_S2 = 2'd2,
        STAGE_S4 = 2'd3
    } op_stage_e;

    // Channel layout of one stage
    localparam ch_t CH_LAST = 3'd6;
    localparam ch_t CH_SKIP = 3'd3;

    // Slots borrowed for ADPCM data
    localparam ch_t       ADPCMA_CH   = 3'd0;
    localparam ch_t       ADPCMB_CH   = 3'd4;
    localparam op_stage_e ADPCM_STAGE = STAGE_S1;

    // Six channels times four stages
    localparam int SLOTS_PER_FRAME = 24;

endpackage
